// ==== include/tile_data_defines.svh ====
`ifndef TILE_DATA_DEFINES_SVH
`define TILE_DATA_DEFINES_SVH

// Bus widths
`define TD_ADDR_W 32
`define TD_DATA_W 32
`define TD_STRB_W 4
`define TD_AMO_W 4

// Reorder ID, 8 outstanding requests
`define TD_ID_W 3

// Local TCDM banks
`define TD_NR_TCDM 2
`define TD_BANK_WORDS 64
`define TD_BANK_IDX_W 6
`define TD_BYTE_OFS_W 2

// Address map, port index covers banks plus the SoC port
`define TD_NUM_RULES 2
`define TD_PORT_W 2

// Outstanding SoC reads
`define TD_SOC_FIFO_DEPTH 8
`define TD_FIFO_PTR_W 3

`endif

// ==== hdl/tile_data_pkg.sv ====
`include "tile_data_defines.svh"

package tile_data_pkg;

  // Atomic operation carried with each request
  typedef enum logic [`TD_AMO_W-1:0] {
    AMO_NONE = 4'h0,
    AMO_SWAP = 4'h1,
    AMO_ADD  = 4'h2
  } amo_op_e;

  // Core request payload
  typedef struct packed {
    logic [`TD_ADDR_W-1:0] addr;
    logic                  write;
    amo_op_e               amo;
    logic [`TD_DATA_W-1:0] data;
    logic [`TD_STRB_W-1:0] strb;
    logic [`TD_ID_W-1:0]   id;
  } dreq_t;

  // Response payload back to the core
  typedef struct packed {
    logic [`TD_DATA_W-1:0] data;
    logic                  error;
    logic [`TD_ID_W-1:0]   id;
  } dresp_t;

  // One address window, end_addr is exclusive
  // idx selects a bank, or the SoC port when equal to the bank count
  typedef struct packed {
    logic [`TD_ADDR_W-1:0] start_addr;
    logic [`TD_ADDR_W-1:0] end_addr;
    logic [`TD_PORT_W-1:0] idx;
  } addr_rule_t;

endpackage

// ==== hdl/soc_id_fifo.sv ====
`timescale 1ns/10ps

`include "tile_data_defines.svh"

module soc_id_fifo (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                push_i,
  input  logic [`TD_ID_W-1:0] id_i,
  input  logic                pop_i,
  output logic [`TD_ID_W-1:0] id_o,
  output logic                full_o,
  output logic                empty_o
);

  localparam logic [`TD_FIFO_PTR_W:0] Depth = `TD_SOC_FIFO_DEPTH;

  logic [`TD_ID_W-1:0]       mem_q [`TD_SOC_FIFO_DEPTH];
  logic [`TD_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [`TD_FIFO_PTR_W-1:0] rd_ptr_q;
  logic [`TD_FIFO_PTR_W:0]   count_q;
  logic                      do_push;
  logic                      do_pop;

  assign full_o  = (count_q == Depth);
  assign empty_o = (count_q == '0);

  // Push into a full queue or pop from an empty one is dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign id_o = mem_q[rd_ptr_q];

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= id_i;
    end
  end

endmodule

// ==== hdl/resp_arbiter.sv ====
`timescale 1ns/10ps

`include "tile_data_defines.svh"

module resp_arbiter (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  tile_data_pkg::dresp_t [`TD_NR_TCDM:0] in_p_i,
  input  logic                  [`TD_NR_TCDM:0] in_pvalid_i,
  output logic                  [`TD_NR_TCDM:0] in_pready_o,
  output tile_data_pkg::dresp_t                 out_p_o,
  output logic                                  out_pvalid_o,
  input  logic                                  out_pready_i
);

  localparam int unsigned NumIn = `TD_NR_TCDM + 1;
  localparam logic [`TD_PORT_W-1:0] LastIdx = `TD_NR_TCDM;

  logic [`TD_PORT_W-1:0] rr_q;
  logic [`TD_PORT_W-1:0] gnt;
  logic                  gnt_valid;
  logic                  lock_q;
  logic [`TD_PORT_W-1:0] lock_idx_q;
  logic                  xfer;

  // Search from the priority pointer, first valid source wins
  always_comb begin
    int unsigned cand;
    gnt       = rr_q;
    gnt_valid = 1'b0;
    for (int k = 0; k < NumIn; k++) begin
      cand = (int'(rr_q) + k) % NumIn;
      if (!gnt_valid && in_pvalid_i[cand]) begin
        gnt_valid = 1'b1;
        gnt       = cand[`TD_PORT_W-1:0];
      end
    end
    // Stalled grant stays put so the payload is stable
    if (lock_q) begin
      gnt       = lock_idx_q;
      gnt_valid = in_pvalid_i[lock_idx_q];
    end
  end

  assign out_p_o      = in_p_i[gnt];
  assign out_pvalid_o = gnt_valid;
  assign xfer         = gnt_valid && out_pready_i;

  always_comb begin
    in_pready_o      = '0;
    in_pready_o[gnt] = out_pready_i && gnt_valid;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (xfer) begin
        rr_q <= (gnt == LastIdx) ? '0 : gnt + 1'b1;
      end
      lock_q     <= gnt_valid && !out_pready_i;
      lock_idx_q <= gnt;
    end
  end

endmodule

// ==== hdl/tcdm_shim.sv ====
`timescale 1ns/10ps

`include "tile_data_defines.svh"

module tcdm_shim (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  // Core request channel
  input  tile_data_pkg::dreq_t                         data_q_i,
  input  logic                                         data_qvalid_i,
  output logic                                         data_qready_o,
  // Core response channel
  output tile_data_pkg::dresp_t                        data_p_o,
  output logic                                         data_pvalid_o,
  input  logic                                         data_pready_i,
  // Banks
  output tile_data_pkg::dreq_t  [`TD_NR_TCDM-1:0]      bank_q_o,
  output logic                  [`TD_NR_TCDM-1:0]      bank_qvalid_o,
  input  logic                  [`TD_NR_TCDM-1:0]      bank_qready_i,
  input  tile_data_pkg::dresp_t [`TD_NR_TCDM-1:0]      bank_p_i,
  input  logic                  [`TD_NR_TCDM-1:0]      bank_pvalid_i,
  output logic                  [`TD_NR_TCDM-1:0]      bank_pready_o,
  // SoC port
  output tile_data_pkg::dreq_t                         soc_q_o,
  output logic                                         soc_qvalid_o,
  input  logic                                         soc_qready_i,
  input  logic                  [`TD_DATA_W-1:0]       soc_pdata_i,
  input  logic                                         soc_perror_i,
  input  logic                                         soc_pvalid_i,
  output logic                                         soc_pready_o,
  // Address map
  input  tile_data_pkg::addr_rule_t [`TD_NUM_RULES-1:0] address_map_i
);

  localparam logic [`TD_PORT_W-1:0] SocPort = `TD_NR_TCDM;

  logic [`TD_PORT_W-1:0]  tgt;
  logic                   rule_hit;
  logic [`TD_NR_TCDM:0]   tgt_sel;
  logic                   needs_resp;
  logic                   soc_blocked;
  logic                   soc_ready_eff;

  logic                   id_push;
  logic                   id_pop;
  logic [`TD_ID_W-1:0]    id_head;
  logic                   id_full;
  logic                   id_empty;

  tile_data_pkg::dresp_t                  soc_p;
  tile_data_pkg::dresp_t [`TD_NR_TCDM:0]  arb_p;
  logic                  [`TD_NR_TCDM:0]  arb_pvalid;
  logic                  [`TD_NR_TCDM:0]  arb_pready;

  // Address decode, lowest matching rule wins
  always_comb begin
    tgt      = SocPort;
    rule_hit = 1'b0;
    for (int r = 0; r < `TD_NUM_RULES; r++) begin
      if (!rule_hit &&
          data_q_i.addr >= address_map_i[r].start_addr &&
          data_q_i.addr <  address_map_i[r].end_addr) begin
        rule_hit = 1'b1;
        // Anything past the last bank means SoC
        tgt = (address_map_i[r].idx < SocPort) ? address_map_i[r].idx : SocPort;
      end
    end
  end

  always_comb begin
    tgt_sel      = '0;
    tgt_sel[tgt] = 1'b1;
  end

  // Loads and atomics expect a response
  assign needs_resp = !data_q_i.write || (data_q_i.amo != tile_data_pkg::AMO_NONE);

  // No room to remember the ID of another SoC read
  assign soc_blocked   = needs_resp && id_full;
  assign soc_ready_eff = soc_qready_i && !soc_blocked;

  // Request steering
  assign bank_q_o      = {`TD_NR_TCDM{data_q_i}};
  assign bank_qvalid_o = {`TD_NR_TCDM{data_qvalid_i}} & tgt_sel[`TD_NR_TCDM-1:0];
  assign soc_q_o       = data_q_i;
  assign soc_qvalid_o  = data_qvalid_i && tgt_sel[`TD_NR_TCDM] && !soc_blocked;
  assign data_qready_o = |(tgt_sel & {soc_ready_eff, bank_qready_i});

  assign id_push = soc_qvalid_o && soc_qready_i && needs_resp;
  assign id_pop  = soc_pvalid_i && soc_pready_o;

  soc_id_fifo i_soc_id_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .push_i  (id_push),
    .id_i    (data_q_i.id),
    .pop_i   (id_pop),
    .id_o    (id_head),
    .full_o  (id_full),
    .empty_o (id_empty)
  );

  // SoC responses come back in order, tag with the oldest ID
  assign soc_p.data  = soc_pdata_i;
  assign soc_p.error = soc_perror_i;
  assign soc_p.id    = id_head;

  assign arb_p      = {soc_p, bank_p_i};
  assign arb_pvalid = {soc_pvalid_i && !id_empty, bank_pvalid_i};

  assign bank_pready_o = arb_pready[`TD_NR_TCDM-1:0];
  assign soc_pready_o  = arb_pready[`TD_NR_TCDM];

  resp_arbiter i_resp_arbiter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_p_i      (arb_p),
    .in_pvalid_i (arb_pvalid),
    .in_pready_o (arb_pready),
    .out_p_o     (data_p_o),
    .out_pvalid_o(data_pvalid_o),
    .out_pready_i(data_pready_i)
  );

endmodule

// ==== hdl/tcdm_bank.sv ====
`timescale 1ns/10ps

`include "tile_data_defines.svh"

module tcdm_bank (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  tile_data_pkg::dreq_t  req_i,
  input  logic                  qvalid_i,
  output logic                  qready_o,
  output tile_data_pkg::dresp_t resp_o,
  output logic                  pvalid_o,
  input  logic                  pready_i
);

  logic [`TD_DATA_W-1:0]    mem_q [`TD_BANK_WORDS];
  logic [`TD_BANK_IDX_W-1:0] word_idx;
  logic [`TD_DATA_W-1:0]    old_word;
  logic [`TD_DATA_W-1:0]    new_word;
  logic                     mem_we;
  logic                     needs_resp;
  logic                     accept;

  logic [`TD_DATA_W-1:0]    resp_data_q;
  logic [`TD_ID_W-1:0]      resp_id_q;
  logic                     pvalid_q;

  // Word index wraps within the bank
  assign word_idx = req_i.addr[`TD_BYTE_OFS_W +: `TD_BANK_IDX_W];
  assign old_word = mem_q[word_idx];

  assign needs_resp = !req_i.write || (req_i.amo != tile_data_pkg::AMO_NONE);

  // Free slot, or the held response leaves this cycle
  assign qready_o = !pvalid_q || pready_i;
  assign accept   = qvalid_i && qready_o;

  always_comb begin
    new_word = old_word;
    mem_we   = 1'b0;
    case (req_i.amo)
      tile_data_pkg::AMO_SWAP: begin
        new_word = req_i.data;
        mem_we   = 1'b1;
      end
      tile_data_pkg::AMO_ADD: begin
        new_word = old_word + req_i.data;
        mem_we   = 1'b1;
      end
      default: begin
        if (req_i.write) begin
          for (int b = 0; b < `TD_STRB_W; b++) begin
            if (req_i.strb[b]) begin
              new_word[8*b +: 8] = req_i.data[8*b +: 8];
            end
          end
          mem_we = 1'b1;
        end
      end
    endcase
  end

  // Banks come out of reset cleared
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < `TD_BANK_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (accept && mem_we) begin
      mem_q[word_idx] <= new_word;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pvalid_q <= 1'b0;
    end else if (accept && needs_resp) begin
      pvalid_q <= 1'b1;
    end else if (pready_i) begin
      pvalid_q <= 1'b0;
    end
  end

  // Loads and atomics both return the word before the update
  always_ff @(posedge clk_i) begin
    if (accept && needs_resp) begin
      resp_data_q <= old_word;
      resp_id_q   <= req_i.id;
    end
  end

  assign resp_o.data  = resp_data_q;
  assign resp_o.error = 1'b0;
  assign resp_o.id    = resp_id_q;
  assign pvalid_o     = pvalid_q;

endmodule

// ==== hdl/tile_data_top.sv ====
`timescale 1ns/10ps

`include "tile_data_defines.svh"

module tile_data_top (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  // Core
  input  tile_data_pkg::dreq_t                          data_q_i,
  input  logic                                          data_qvalid_i,
  output logic                                          data_qready_o,
  output tile_data_pkg::dresp_t                         data_p_o,
  output logic                                          data_pvalid_o,
  input  logic                                          data_pready_i,
  // SoC
  output tile_data_pkg::dreq_t                          soc_q_o,
  output logic                                          soc_qvalid_o,
  input  logic                                          soc_qready_i,
  input  logic [`TD_DATA_W-1:0]                         soc_pdata_i,
  input  logic                                          soc_perror_i,
  input  logic                                          soc_pvalid_i,
  output logic                                          soc_pready_o,
  // Address map
  input  tile_data_pkg::addr_rule_t [`TD_NUM_RULES-1:0] address_map_i
);

  tile_data_pkg::dreq_t  [`TD_NR_TCDM-1:0] bank_q;
  logic                  [`TD_NR_TCDM-1:0] bank_qvalid;
  logic                  [`TD_NR_TCDM-1:0] bank_qready;
  tile_data_pkg::dresp_t [`TD_NR_TCDM-1:0] bank_p;
  logic                  [`TD_NR_TCDM-1:0] bank_pvalid;
  logic                  [`TD_NR_TCDM-1:0] bank_pready;

  tcdm_shim i_tcdm_shim (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .data_q_i     (data_q_i),
    .data_qvalid_i(data_qvalid_i),
    .data_qready_o(data_qready_o),
    .data_p_o     (data_p_o),
    .data_pvalid_o(data_pvalid_o),
    .data_pready_i(data_pready_i),
    .bank_q_o     (bank_q),
    .bank_qvalid_o(bank_qvalid),
    .bank_qready_i(bank_qready),
    .bank_p_i     (bank_p),
    .bank_pvalid_i(bank_pvalid),
    .bank_pready_o(bank_pready),
    .soc_q_o      (soc_q_o),
    .soc_qvalid_o (soc_qvalid_o),
    .soc_qready_i (soc_qready_i),
    .soc_pdata_i  (soc_pdata_i),
    .soc_perror_i (soc_perror_i),
    .soc_pvalid_i (soc_pvalid_i),
    .soc_pready_o (soc_pready_o),
    .address_map_i(address_map_i)
  );

  for (genvar i = 0; i < `TD_NR_TCDM; i++) begin : gen_bank
    tcdm_bank i_tcdm_bank (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .req_i   (bank_q[i]),
      .qvalid_i(bank_qvalid[i]),
      .qready_o(bank_qready[i]),
      .resp_o  (bank_p[i]),
      .pvalid_o(bank_pvalid[i]),
      .pready_i(bank_pready[i])
    );
  end

endmodule

// ==== dv/tb_tile_data_top.sv ====
`timescale 1ns/10ps

`include "tile_data_defines.svh"

module tb_tile_data_top;

  localparam int unsigned Timeout = 2000;
  localparam int unsigned NumIds = 1 << `TD_ID_W;
  localparam logic [`TD_ADDR_W-1:0] BankSpan = `TD_BANK_WORDS * 4;
  localparam logic [`TD_ADDR_W-1:0] SocBase = 32'h1000_0000;
  localparam logic [`TD_ADDR_W-1:0] ErrAddr = 32'h1000_0040;

  logic                                          clk_i;
  logic                                          arst_n_i;
  tile_data_pkg::dreq_t                          data_q_i;
  logic                                          data_qvalid_i;
  logic                                          data_qready_o;
  tile_data_pkg::dresp_t                         data_p_o;
  logic                                          data_pvalid_o;
  logic                                          data_pready_i;
  tile_data_pkg::dreq_t                          soc_q_o;
  logic                                          soc_qvalid_o;
  logic                                          soc_qready_i;
  logic [`TD_DATA_W-1:0]                         soc_pdata_i;
  logic                                          soc_perror_i;
  logic                                          soc_pvalid_i;
  logic                                          soc_pready_o;
  tile_data_pkg::addr_rule_t [`TD_NUM_RULES-1:0] address_map_i;

  // Reference memory covers both banks back to back
  logic [`TD_DATA_W-1:0] ref_mem [2*`TD_BANK_WORDS];
  logic [`TD_DATA_W-1:0] exp_data [NumIds];
  logic                  exp_err [NumIds];
  int unsigned           issued_cnt [NumIds];
  int unsigned           returned_cnt [NumIds];
  int unsigned           n_expected;
  int unsigned           n_got;
  int unsigned           lcg_state = 17364;
  logic [`TD_ID_W-1:0]   next_id;
  logic [`TD_ADDR_W-1:0] cur_addr;
  logic [`TD_ADDR_W-1:0] soc_addr_q [$];
  string                 test_name;

  tile_data_top uut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .data_q_i     (data_q_i),
    .data_qvalid_i(data_qvalid_i),
    .data_qready_o(data_qready_o),
    .data_p_o     (data_p_o),
    .data_pvalid_o(data_pvalid_o),
    .data_pready_i(data_pready_i),
    .soc_q_o      (soc_q_o),
    .soc_qvalid_o (soc_qvalid_o),
    .soc_qready_i (soc_qready_i),
    .soc_pdata_i  (soc_pdata_i),
    .soc_perror_i (soc_perror_i),
    .soc_pvalid_i (soc_pvalid_i),
    .soc_pready_o (soc_pready_o),
    .address_map_i(address_map_i)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  // SoC memory is a fixed scramble of the address
  function automatic logic [`TD_DATA_W-1:0] soc_data(input logic [`TD_ADDR_W-1:0] addr);
    return {addr[15:0], ~addr[15:0]} ^ 32'hA5C3_0F96;
  endfunction

  // Expected response data, updates the reference memory like an accepted request
  function automatic logic [`TD_DATA_W-1:0] ref_result(
    input logic [`TD_ADDR_W-1:0]  addr,
    input logic                   write,
    input tile_data_pkg::amo_op_e amo,
    input logic [`TD_DATA_W-1:0]  data,
    input logic [`TD_STRB_W-1:0]  strb
  );
    logic [`TD_BANK_IDX_W:0] idx;
    logic [`TD_DATA_W-1:0]   old;
    if (addr >= BankSpan + BankSpan) begin
      return soc_data(addr);
    end
    idx = addr[`TD_BYTE_OFS_W +: `TD_BANK_IDX_W + 1];
    old = ref_mem[idx];
    if (amo == tile_data_pkg::AMO_SWAP) begin
      ref_mem[idx] = data;
    end else if (amo == tile_data_pkg::AMO_ADD) begin
      ref_mem[idx] = old + data;
    end else if (write) begin
      for (int b = 0; b < `TD_STRB_W; b++) begin
        if (strb[b]) begin
          ref_mem[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    return old;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch %s expected %0h actual %0h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting: %s", what);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic issue(
    input logic [`TD_ADDR_W-1:0]  addr,
    input logic                   write,
    input tile_data_pkg::amo_op_e amo,
    input logic [`TD_DATA_W-1:0]  data,
    input logic [`TD_STRB_W-1:0]  strb
  );
    int unsigned           t;
    logic                  accepted;
    logic                  resp;
    logic [`TD_DATA_W-1:0] exp;
    resp = !write || (amo != tile_data_pkg::AMO_NONE);
    t = 0;
    // Reorder ID must come back before reuse
    while (resp && issued_cnt[next_id] != returned_cnt[next_id]) begin
      @(posedge clk_i);
      #2;
      t++;
      if (t > Timeout) report_timeout("reorder ID never returned");
    end
    data_q_i.addr  = addr;
    data_q_i.write = write;
    data_q_i.amo   = amo;
    data_q_i.data  = data;
    data_q_i.strb  = strb;
    data_q_i.id    = next_id;
    data_qvalid_i  = 1'b1;
    cur_addr       = addr;
    accepted = 1'b0;
    t = 0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = data_qready_o;
      @(posedge clk_i);
      t++;
      if (!accepted && t > Timeout) report_timeout("request never accepted");
    end
    exp = ref_result(addr, write, amo, data, strb);
    if (resp) begin
      exp_data[next_id] = exp;
      exp_err[next_id]  = (addr == ErrAddr);
      issued_cnt[next_id]++;
      n_expected++;
      next_id = next_id + 1'b1;
    end
    #2;
    data_qvalid_i = 1'b0;
  endtask

  task automatic load(input logic [`TD_ADDR_W-1:0] addr);
    issue(addr, 1'b0, tile_data_pkg::AMO_NONE, '0, '0);
  endtask

  task automatic wait_idle();
    int unsigned t;
    t = 0;
    while (n_got != n_expected) begin
      @(posedge clk_i);
      #2;
      t++;
      if (t > Timeout) report_timeout("core responses still outstanding");
    end
  endtask

  // Response checker with random ready gaps
  initial begin : compare_proc
    logic [`TD_ID_W-1:0] id;
    logic                take;
    data_pready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      take = data_pvalid_o && data_pready_i;
      id   = data_p_o.id;
      if (take && issued_cnt[id] == returned_cnt[id]) begin
        $display("Response with ID %0d has no outstanding request", id);
        $display(">>> FAIL");
        $fatal(1);
      end else begin
        if (take) begin
          check_eq(test_name, 64'({exp_data[id], exp_err[id], id}), 64'(data_p_o));
        end
        @(posedge clk_i);
        if (take) begin
          returned_cnt[id]++;
          n_got++;
        end
        #2;
        data_pready_i = (lcg_next() % 4) != 0;
      end
    end
  end

  // SoC side, answers reads in order after random delays
  initial begin : soc_model
    logic                  take_q;
    logic                  take_p;
    logic                  req_read;
    logic [`TD_ADDR_W-1:0] req_addr;
    soc_qready_i = 1'b0;
    soc_pvalid_i = 1'b0;
    soc_pdata_i  = '0;
    soc_perror_i = 1'b0;
    forever begin
      @(negedge clk_i);
      take_q   = soc_qvalid_o && soc_qready_i;
      take_p   = soc_pvalid_i && soc_pready_o;
      req_addr = soc_q_o.addr;
      req_read = !soc_q_o.write || (soc_q_o.amo != tile_data_pkg::AMO_NONE);
      if (take_q) begin
        check_eq("soc_request_addr", 64'(cur_addr), 64'(req_addr));
      end
      @(posedge clk_i);
      if (take_q && req_read) soc_addr_q.push_back(req_addr);
      if (take_p) soc_addr_q.delete(0);
      #2;
      soc_qready_i = (lcg_next() % 3) != 0;
      if (take_p) soc_pvalid_i = 1'b0;
      if (!soc_pvalid_i && soc_addr_q.size() > 0 && (lcg_next() % 2) == 0) begin
        soc_pvalid_i = 1'b1;
        soc_pdata_i  = soc_data(soc_addr_q[0]);
        soc_perror_i = (soc_addr_q[0] == ErrAddr);
      end
    end
  end

  initial begin : main_proc
    logic [31:0]           rnd;
    logic [`TD_ADDR_W-1:0] addr;
    logic [`TD_ADDR_W-1:0] st_addr [16];
    arst_n_i      = 1'b0;
    data_qvalid_i = 1'b0;
    data_q_i      = '0;
    next_id       = '0;
    n_expected    = 0;
    n_got         = 0;
    test_name     = "reset";
    address_map_i[0].start_addr = '0;
    address_map_i[0].end_addr   = BankSpan;
    address_map_i[0].idx        = 2'd0;
    address_map_i[1].start_addr = BankSpan;
    address_map_i[1].end_addr   = BankSpan + BankSpan;
    address_map_i[1].idx        = 2'd1;
    for (int i = 0; i < NumIds; i++) begin
      issued_cnt[i]   = 0;
      returned_cnt[i] = 0;
    end
    for (int w = 0; w < 2*`TD_BANK_WORDS; w++) begin
      ref_mem[w] = '0;
    end
    repeat (10) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    @(negedge clk_i);
    check_eq("reset_pvalid", 64'd0, 64'(data_pvalid_o));
    check_eq("reset_soc_qvalid", 64'd0, 64'(soc_qvalid_o));
    @(posedge clk_i);
    #2;
    for (int w = 0; w < 2*`TD_BANK_WORDS; w++) begin
      load(w * 4);
    end
    wait_idle();

    test_name = "strobed_store";
    for (int i = 0; i < 16; i++) begin
      rnd        = lcg_next();
      st_addr[i] = {23'd0, rnd[6:0], 2'b00};
      rnd        = lcg_next();
      issue(st_addr[i], 1'b1, tile_data_pkg::AMO_NONE, lcg_next(), rnd[3:0]);
    end
    for (int i = 0; i < 16; i++) begin
      load(st_addr[i]);
    end
    wait_idle();

    test_name = "atomics";
    for (int i = 0; i < 8; i++) begin
      rnd  = lcg_next();
      addr = {23'd0, rnd[6:0], 2'b00};
      issue(addr, 1'b1, (i % 2 == 0) ? tile_data_pkg::AMO_SWAP : tile_data_pkg::AMO_ADD,
            lcg_next(), 4'hF);
      load(addr);
    end
    wait_idle();

    // Range steps across the error address
    test_name = "soc_access";
    for (int i = 0; i < 12; i++) begin
      if (i == 3) issue(SocBase + 32'h80, 1'b1, tile_data_pkg::AMO_NONE, lcg_next(), 4'hF);
      load(SocBase + i * 8);
    end
    wait_idle();

    test_name = "interleaved";
    for (int i = 0; i < 40; i++) begin
      rnd = lcg_next();
      if (rnd[0]) begin
        addr = {23'd0, rnd[9:3], 2'b00};
      end else begin
        addr = SocBase + {24'd0, rnd[8:3], 2'b00};
      end
      load(addr);
    end
    wait_idle();

    // Nothing may be left on the response channel once all IDs are back
    @(negedge clk_i);
    check_eq("stray_response", 64'd0, 64'(data_pvalid_o));
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== tile_data_top.f ====
+incdir+include
hdl/tile_data_pkg.sv
hdl/soc_id_fifo.sv
hdl/resp_arbiter.sv
hdl/tcdm_shim.sv
hdl/tcdm_bank.sv
hdl/tile_data_top.sv
dv/tb_tile_data_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the tile data subsystem and its testbench, then run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_tile_data_top \
  -f tile_data_top.f \
  -o sim_tb_tile_data_top

# Exit status of the simulation decides pass or fail
./obj_dir/sim_tb_tile_data_top
